//--- design/decode_pkg.sv
// decode stage definitions for a 32-bit MIPS subset, no CP0, HI/LO or multiply/divide encodings
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mask_t;

    localparam mask_t MASK_WORD = 4'b1111;
    localparam mask_t MASK_NONE = 4'b0000;

    typedef enum logic [4:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ,
        OP_J, OP_JAL, OP_JR, OP_UNKNOWN
    } alu_op_e;

    typedef enum logic [2:0] {
        OP1_NONE, OP1_RS, OP1_SHAMT, OP1_LUI, OP1_PC
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_NONE, OP2_RT, OP2_IMM_SIGNED, OP2_IMM_ZERO, OP2_LINK
    } op2_sel_e;

    // instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int RS_MSB     = 25;
    localparam int RS_LSB     = 21;
    localparam int RT_MSB     = 20;
    localparam int RT_LSB     = 16;
    localparam int RD_MSB     = 15;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_MSB  = 10;
    localparam int SHAMT_LSB  = 6;
    localparam int FUNCT_MSB  = 5;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_MSB    = 15;
    localparam int IMM_LSB    = 0;
    localparam int TARGET_MSB = 25;
    localparam int TARGET_LSB = 0;

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_REGIMM  = 6'h01;  // bltz with rt == 0
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_BLEZ    = 6'h06;
    localparam logic [5:0] OPC_BGTZ    = 6'h07;
    localparam logic [5:0] OPC_ADDI    = 6'h08;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_SLTIU   = 6'h0b;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // funct codes under OPC_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam reg_addr_t LINK_REG    = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd4;  // one instruction, also the delay slot step

endpackage

//--- design/id_operand_fetch.sv
// stage register plus forwarding, bypass index 0 has top priority and r0 is not special-cased
`timescale 1ns/1ps

module id_operand_fetch
    import decode_pkg::*;
#(
    parameter int NUM_BYPASS = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  word_t                      pc,
    input  word_t                      inst,
    input  word_t                      rega_data_in,
    input  word_t                      regb_data_in,
    input  logic      [NUM_BYPASS-1:0] byp_wr,
    input  reg_addr_t [NUM_BYPASS-1:0] byp_addr,
    input  word_t     [NUM_BYPASS-1:0] byp_data,
    output word_t                      id_pc,
    output word_t                      id_inst,
    output reg_addr_t                  rega_addr,
    output reg_addr_t                  regb_addr,
    output word_t                      rs_val,
    output word_t                      rt_val
);

    // lowest index that matches wins, else the register file value
    function automatic word_t fwd_pick(input reg_addr_t addr, input word_t rf_val);
        word_t val;
        val = rf_val;
        for (int i = NUM_BYPASS - 1; i >= 0; i--) begin
            if (byp_wr[i] && (byp_addr[i] == addr)) begin
                val = byp_data[i];
            end
        end
        return val;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_pc   <= '0;
            id_inst <= '0;  // decodes as nop
        end else begin
            id_pc   <= pc;
            id_inst <= inst;
        end
    end

    assign rega_addr = id_inst[RS_MSB:RS_LSB];
    assign regb_addr = id_inst[RT_MSB:RT_LSB];

    always_comb begin
        rs_val = fwd_pick(rega_addr, rega_data_in);
        rt_val = fwd_pick(regb_addr, regb_data_in);
    end

    // fetch must never hand over an undriven instruction once out of reset
    a_inst_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(id_inst))
        else $error("id_inst holds X or Z");

endmodule

//--- design/instr_decoder.sv
// MIPS subset decoder, reserved fields must be zero or the op decodes as unknown with no writes
`timescale 1ns/1ps

module instr_decoder
    import decode_pkg::*;
(
    input  logic      rst,
    input  word_t     id_inst,
    output alu_op_e   alu_op,
    output op1_sel_e  op1_sel,
    output op2_sel_e  op2_sel,
    output logic      mem_wr,
    output logic      mem_rd,
    output mask_t     w_mask,
    output mask_t     r_mask,
    output logic      regc_wr,
    output reg_addr_t regc_addr
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       rs_z;
    logic       rt_z;
    logic       rd_z;
    logic       shamt_z;
    logic       is_special;

    assign opcode     = id_inst[OPCODE_MSB:OPCODE_LSB];
    assign funct      = id_inst[FUNCT_MSB:FUNCT_LSB];
    assign rt         = id_inst[RT_MSB:RT_LSB];
    assign rd         = id_inst[RD_MSB:RD_LSB];
    assign rs_z       = (id_inst[RS_MSB:RS_LSB] == '0);
    assign rt_z       = (rt == '0);
    assign rd_z       = (rd == '0);
    assign shamt_z    = (id_inst[SHAMT_MSB:SHAMT_LSB] == '0);
    assign is_special = (opcode == OPC_SPECIAL);

    // opcode and funct to alu op
    always_comb begin
        alu_op = OP_UNKNOWN;
        if (rst || (id_inst == '0)) begin
            alu_op = OP_NOP;  // all-zero word is nop, not sll r0
        end else begin
            case (opcode)
                OPC_SPECIAL: begin
                    case (funct)
                        FN_ADD, FN_ADDU: alu_op = shamt_z ? OP_ADD : OP_UNKNOWN;
                        FN_SUB, FN_SUBU: alu_op = shamt_z ? OP_SUB : OP_UNKNOWN;
                        FN_AND:          alu_op = shamt_z ? OP_AND : OP_UNKNOWN;
                        FN_OR:           alu_op = shamt_z ? OP_OR : OP_UNKNOWN;
                        FN_XOR:          alu_op = shamt_z ? OP_XOR : OP_UNKNOWN;
                        FN_SLT:          alu_op = shamt_z ? OP_SLT : OP_UNKNOWN;
                        FN_SLL:          alu_op = rs_z ? OP_SLL : OP_UNKNOWN;
                        FN_SRL:          alu_op = rs_z ? OP_SRL : OP_UNKNOWN;
                        FN_SRA:          alu_op = rs_z ? OP_SRA : OP_UNKNOWN;
                        FN_JR:   alu_op = (rt_z && rd_z && shamt_z) ? OP_JR : OP_UNKNOWN;
                        default:         alu_op = OP_UNKNOWN;
                    endcase
                end
                OPC_REGIMM: alu_op = rt_z ? OP_BLTZ : OP_UNKNOWN;
                OPC_BLEZ:   alu_op = rt_z ? OP_BLEZ : OP_UNKNOWN;
                OPC_BGTZ:   alu_op = rt_z ? OP_BGTZ : OP_UNKNOWN;
                OPC_LUI:    alu_op = rs_z ? OP_LUI : OP_UNKNOWN;
                OPC_BEQ:    alu_op = OP_BEQ;
                OPC_BNE:    alu_op = OP_BNE;
                OPC_J:      alu_op = OP_J;
                OPC_JAL:    alu_op = OP_JAL;
                OPC_ADDI, OPC_ADDIU: alu_op = OP_ADD;
                OPC_SLTI:   alu_op = OP_SLT;
                OPC_SLTIU:  alu_op = OP_SLTU;
                OPC_ANDI:   alu_op = OP_AND;
                OPC_ORI:    alu_op = OP_OR;
                OPC_XORI:   alu_op = OP_XOR;
                OPC_LW:     alu_op = OP_LW;
                OPC_SW:     alu_op = OP_SW;
                default:    alu_op = OP_UNKNOWN;
            endcase
        end
    end

    // control set per alu op
    always_comb begin
        op1_sel   = OP1_NONE;
        op2_sel   = OP2_NONE;
        mem_wr    = 1'b0;
        mem_rd    = 1'b0;
        w_mask    = MASK_NONE;
        r_mask    = MASK_NONE;
        regc_wr   = 1'b0;
        regc_addr = '0;
        case (alu_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU: begin
                op1_sel = OP1_RS;
                regc_wr = 1'b1;
                if (is_special) begin
                    op2_sel   = OP2_RT;
                    regc_addr = rd;
                end else begin
                    // logical immediates are zero-extended
                    op2_sel   = (alu_op inside {OP_AND, OP_OR, OP_XOR}) ? OP2_IMM_ZERO
                                                                         : OP2_IMM_SIGNED;
                    regc_addr = rt;
                end
            end
            OP_SLL, OP_SRL, OP_SRA: begin
                op1_sel   = OP1_SHAMT;
                op2_sel   = OP2_RT;
                regc_wr   = 1'b1;
                regc_addr = rd;
            end
            OP_LUI: begin
                op1_sel   = OP1_LUI;
                regc_wr   = 1'b1;
                regc_addr = rt;
            end
            OP_LW: begin
                op1_sel   = OP1_RS;   // base
                op2_sel   = OP2_IMM_SIGNED;
                mem_rd    = 1'b1;
                r_mask    = MASK_WORD;
                regc_wr   = 1'b1;
                regc_addr = rt;
            end
            OP_SW: begin
                op1_sel = OP1_RS;
                op2_sel = OP2_IMM_SIGNED;
                mem_wr  = 1'b1;
                w_mask  = MASK_WORD;
            end
            OP_JAL: begin
                op1_sel   = OP1_PC;   // link = pc + 4
                op2_sel   = OP2_LINK;
                regc_wr   = 1'b1;
                regc_addr = LINK_REG;
            end
            default: ;
        endcase
    end

endmodule

//--- design/operand_mux.sv
// operand select for the EXU, unselected operands read as zero
`timescale 1ns/1ps

module operand_mux
    import decode_pkg::*;
(
    input  word_t    id_pc,
    input  word_t    id_inst,
    input  op1_sel_e op1_sel,
    input  op2_sel_e op2_sel,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output word_t    rega_data,
    output word_t    regb_data,
    output word_t    store_data
);

    logic [15:0] imm;
    logic [4:0]  shamt;

    assign imm   = id_inst[IMM_MSB:IMM_LSB];
    assign shamt = id_inst[SHAMT_MSB:SHAMT_LSB];

    always_comb begin
        case (op1_sel)
            OP1_RS:    rega_data = rs_val;
            OP1_SHAMT: rega_data = {27'd0, shamt};
            OP1_LUI:   rega_data = {imm, 16'd0};  // upper half
            OP1_PC:    rega_data = id_pc;
            default:   rega_data = '0;
        endcase
    end

    always_comb begin
        case (op2_sel)
            OP2_RT:         regb_data = rt_val;
            OP2_IMM_SIGNED: regb_data = {{16{imm[15]}}, imm};
            OP2_IMM_ZERO:   regb_data = {16'd0, imm};
            OP2_LINK:       regb_data = LINK_OFFSET;
            default:        regb_data = '0;
        endcase
    end

    assign store_data = rt_val;  // sw data, forwarded

endmodule

//--- design/branch_unit.sv
// branch and jump resolution in decode, targets assume a word-aligned pc
`timescale 1ns/1ps

module branch_unit
    import decode_pkg::*;
(
    input  logic    rst,
    input  word_t   id_pc,
    input  word_t   id_inst,
    input  alu_op_e alu_op,
    input  word_t   rs_val,
    input  word_t   rt_val,
    output logic    jce,
    output word_t   jaddr
);

    logic [15:0] offset;
    word_t       pc_next;
    word_t       br_target;
    word_t       j_target;
    logic        rs_neg;
    logic        rs_zero;

    assign offset    = id_inst[IMM_MSB:IMM_LSB];
    assign pc_next   = id_pc + LINK_OFFSET;  // delay slot
    assign br_target = pc_next + {{14{offset[15]}}, offset, 2'b00};
    assign j_target  = {pc_next[31:28], id_inst[TARGET_MSB:TARGET_LSB], 2'b00};
    assign rs_neg    = rs_val[31];
    assign rs_zero   = (rs_val == '0);

    always_comb begin
        jce   = 1'b0;
        jaddr = '0;
        if (!rst) begin
            case (alu_op)
                OP_BEQ: begin
                    jce   = (rs_val == rt_val);
                    jaddr = br_target;
                end
                OP_BNE: begin
                    jce   = (rs_val != rt_val);
                    jaddr = br_target;
                end
                OP_BLEZ: begin
                    jce   = rs_neg || rs_zero;
                    jaddr = br_target;
                end
                OP_BGTZ: begin
                    jce   = !rs_neg && !rs_zero;  // strictly positive
                    jaddr = br_target;
                end
                OP_BLTZ: begin
                    jce   = rs_neg;
                    jaddr = br_target;
                end
                OP_J, OP_JAL: begin
                    jce   = 1'b1;
                    jaddr = j_target;
                end
                OP_JR: begin
                    jce   = 1'b1;
                    jaddr = rs_val;
                end
                default: ;
            endcase
        end
    end

    // pc alignment from fetch carries through to every computed target
    always_comb begin
        if (!rst && jce && alu_op != OP_JR) begin
            a_target_align: assert final (jaddr[1:0] == 2'b00)
                else $error("jump target not word aligned");
        end
    end

endmodule

//--- design/decode_top.sv
// decode stage top, one cycle from pc/inst to control outputs, no stall or flush input
`timescale 1ns/1ps

module decode_top
    import decode_pkg::*;
#(
    parameter int NUM_BYPASS = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  word_t                      pc,
    input  word_t                      inst,
    input  word_t                      rega_data_in,
    input  word_t                      regb_data_in,
    input  logic      [NUM_BYPASS-1:0] byp_wr,    // 0 exu, 1 mem, 2 wbu
    input  reg_addr_t [NUM_BYPASS-1:0] byp_addr,
    input  word_t     [NUM_BYPASS-1:0] byp_data,
    output reg_addr_t                  rega_addr,
    output reg_addr_t                  regb_addr,
    output alu_op_e                    alu_op,
    output word_t                      rega_data,
    output word_t                      regb_data,
    output word_t                      store_data,
    output logic                       mem_wr,
    output logic                       mem_rd,
    output mask_t                      w_mask,
    output mask_t                      r_mask,
    output logic                       regc_wr,
    output reg_addr_t                  regc_addr,
    output logic                       jce,
    output word_t                      jaddr
);

    word_t    id_pc;
    word_t    id_inst;
    word_t    rs_val;
    word_t    rt_val;
    op1_sel_e op1_sel;
    op2_sel_e op2_sel;

    id_operand_fetch #(
        .NUM_BYPASS (NUM_BYPASS)
    ) fetch_i (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .inst         (inst),
        .rega_data_in (rega_data_in),
        .regb_data_in (regb_data_in),
        .byp_wr       (byp_wr),
        .byp_addr     (byp_addr),
        .byp_data     (byp_data),
        .id_pc        (id_pc),
        .id_inst      (id_inst),
        .rega_addr    (rega_addr),
        .regb_addr    (regb_addr),
        .rs_val       (rs_val),
        .rt_val       (rt_val)
    );

    instr_decoder dec_i (
        .rst       (rst),
        .id_inst   (id_inst),
        .alu_op    (alu_op),
        .op1_sel   (op1_sel),
        .op2_sel   (op2_sel),
        .mem_wr    (mem_wr),
        .mem_rd    (mem_rd),
        .w_mask    (w_mask),
        .r_mask    (r_mask),
        .regc_wr   (regc_wr),
        .regc_addr (regc_addr)
    );

    operand_mux opmux_i (
        .id_pc      (id_pc),
        .id_inst    (id_inst),
        .op1_sel    (op1_sel),
        .op2_sel    (op2_sel),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .rega_data  (rega_data),
        .regb_data  (regb_data),
        .store_data (store_data)
    );

    branch_unit br_i (
        .rst     (rst),
        .id_pc   (id_pc),
        .id_inst (id_inst),
        .alu_op  (alu_op),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .jce     (jce),
        .jaddr   (jaddr)
    );

endmodule

//--- tb/decode_tests.svh
// directed decode tests, encodings keep the reserved fields zero so each one is a legal instruction
`ifndef DECODE_TESTS_SVH
`define DECODE_TESTS_SVH

localparam int ALU_INSTR   = 19;
localparam int FWD_INSTR   = 7;
localparam int MEM_INSTR   = 2;
localparam int BR_ROUNDS   = 8;
localparam int JUMP_INSTR  = 4;
localparam int TEST_CYCLES = 12 + 2 * (ALU_INSTR + FWD_INSTR + MEM_INSTR
                                       + 5 * BR_ROUNDS + JUMP_INSTR);

localparam reg_addr_t FWD_RS  = 5'd7;
localparam reg_addr_t FWD_RT  = 5'd9;
localparam reg_addr_t FWD_OTH = 5'd12;  // matches neither operand

function automatic word_t r_format(input reg_addr_t rs, input reg_addr_t rt,
                                   input reg_addr_t rd, input logic [4:0] sh,
                                   input logic [5:0] fn);
    return {OPC_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic word_t i_format(input logic [5:0] opc, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

function automatic reg_addr_t reg_number();
    word_t w;
    w = next_random();
    return w[20:16];  // upper bits, low LCG bits cycle fast
endfunction

function automatic logic [15:0] imm_value();
    word_t w;
    w = next_random();
    return w[23:8];
endfunction

function automatic word_t sign_ext(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
endfunction

// branch conditions on the rs and rt values
function automatic logic branch_taken(input alu_op_e op, input word_t a, input word_t b);
    case (op)
        OP_BEQ:  return a == b;
        OP_BNE:  return a != b;
        OP_BLEZ: return a[31] || (a == '0);
        OP_BGTZ: return !a[31] && (a != '0);
        default: return a[31];  // bltz
    endcase
endfunction

task automatic verify_inactive(input alu_op_e op);
    check_op("alu_op", alu_op, op);
    check_bit("regc_wr", regc_wr, 1'b0);
    check_bit("mem_wr", mem_wr, 1'b0);
    check_bit("mem_rd", mem_rd, 1'b0);
    check_bit("jce", jce, 1'b0);
    check_mask("w_mask", w_mask, MASK_NONE);
    check_mask("r_mask", r_mask, MASK_NONE);
endtask

task automatic reset_state();
    int e0;
    e0 = err_count;
    @(posedge clk);
    pc   <= 32'h0000_0040;
    inst <= {OPC_JAL, 26'h000_0123};  // held off by the cleared stage register
    repeat (8) @(posedge clk);
    @(negedge clk);
    verify_inactive(OP_NOP);  // rst still high
    @(posedge clk);
    rst <= 1'b0;
    apply_instr('0, '0);
    verify_inactive(OP_NOP);
    record_result("reset state", e0);
endtask

task automatic rtype_case(input logic [5:0] fn, input alu_op_e op);
    reg_addr_t rs, rt, rd;
    rs     = reg_number();
    rt     = reg_number();
    rd     = reg_number();
    rf_a_n = next_random();
    rf_b_n = next_random();
    apply_instr(next_random(), r_format(rs, rt, rd, 5'd0, fn));
    check_op("alu_op", alu_op, op);
    check_addr("rega_addr", rega_addr, rs);
    check_addr("regb_addr", regb_addr, rt);
    check_bit("regc_wr", regc_wr, 1'b1);
    check_addr("regc_addr", regc_addr, rd);
    check_word("rega_data", rega_data, rf_a_n);
    check_word("regb_data", regb_data, rf_b_n);
endtask

task automatic itype_case(input logic [5:0] opc, input alu_op_e op, input logic signed_imm);
    reg_addr_t   rs, rt;
    logic [15:0] imm;
    word_t       exp_b;
    rs     = reg_number();
    rt     = reg_number();
    imm    = imm_value();
    rf_a_n = next_random();
    exp_b  = signed_imm ? sign_ext(imm) : {16'h0000, imm};
    apply_instr(next_random(), i_format(opc, rs, rt, imm));
    check_op("alu_op", alu_op, op);
    check_bit("regc_wr", regc_wr, 1'b1);
    check_addr("regc_addr", regc_addr, rt);
    check_word("rega_data", rega_data, rf_a_n);
    check_word("regb_data", regb_data, exp_b);
endtask

task automatic shift_case(input logic [5:0] fn, input alu_op_e op);
    reg_addr_t  rt, rd;
    logic [4:0] sh;
    rt     = reg_number();
    rd     = reg_number();
    sh     = reg_number();
    rf_b_n = next_random();
    apply_instr(next_random(), r_format(5'd0, rt, rd, sh, fn));
    check_op("alu_op", alu_op, op);
    check_addr("regc_addr", regc_addr, rd);
    check_word("rega_data", rega_data, {27'd0, sh});
    check_word("regb_data", regb_data, rf_b_n);
endtask

task automatic alu_decode();
    int          e0;
    reg_addr_t   rt;
    logic [15:0] imm;
    e0       = err_count;
    byp_wr_n = '0;
    rtype_case(FN_ADD, OP_ADD);
    rtype_case(FN_ADDU, OP_ADD);
    rtype_case(FN_SUB, OP_SUB);
    rtype_case(FN_SUBU, OP_SUB);
    rtype_case(FN_AND, OP_AND);
    rtype_case(FN_OR, OP_OR);
    rtype_case(FN_XOR, OP_XOR);
    rtype_case(FN_SLT, OP_SLT);
    itype_case(OPC_ADDI, OP_ADD, 1'b1);
    itype_case(OPC_ADDIU, OP_ADD, 1'b1);
    itype_case(OPC_SLTI, OP_SLT, 1'b1);
    itype_case(OPC_SLTIU, OP_SLTU, 1'b1);
    itype_case(OPC_ANDI, OP_AND, 1'b0);
    itype_case(OPC_ORI, OP_OR, 1'b0);
    itype_case(OPC_XORI, OP_XOR, 1'b0);
    shift_case(FN_SLL, OP_SLL);
    shift_case(FN_SRL, OP_SRL);
    shift_case(FN_SRA, OP_SRA);
    rt  = reg_number();
    imm = imm_value();
    apply_instr(next_random(), i_format(OPC_LUI, 5'd0, rt, imm));
    check_op("alu_op", alu_op, OP_LUI);
    check_addr("regc_addr", regc_addr, rt);
    check_word("rega_data", rega_data, {imm, 16'h0000});
    record_result("alu decode", e0);
endtask

task automatic forward_case(input logic [2:0] wr, input reg_addr_t a0, input reg_addr_t a1,
                            input reg_addr_t a2, input word_t exp_a, input word_t exp_b);
    byp_wr_n      = wr;
    byp_addr_n[0] = a0;
    byp_addr_n[1] = a1;
    byp_addr_n[2] = a2;
    apply_instr(32'h0000_0100, r_format(FWD_RS, FWD_RT, 5'd1, 5'd0, FN_ADD));
    check_word("rega_data", rega_data, exp_a);
    check_word("regb_data", regb_data, exp_b);
endtask

task automatic forward_priority();
    int e0;
    e0            = err_count;
    rf_a_n        = next_random();
    rf_b_n        = next_random();
    byp_data_n[0] = next_random();  // exu
    byp_data_n[1] = next_random();  // mem
    byp_data_n[2] = next_random();  // wbu
    forward_case(3'b111, FWD_RS, FWD_RS, FWD_RS, byp_data_n[0], rf_b_n);
    forward_case(3'b110, FWD_RS, FWD_RS, FWD_RS, byp_data_n[1], rf_b_n);
    forward_case(3'b111, FWD_OTH, FWD_OTH, FWD_RS, byp_data_n[2], rf_b_n);
    forward_case(3'b111, FWD_OTH, FWD_OTH, FWD_OTH, rf_a_n, rf_b_n);
    forward_case(3'b111, FWD_RT, FWD_RT, FWD_RT, rf_a_n, byp_data_n[0]);
    forward_case(3'b110, FWD_RT, FWD_RT, FWD_RT, rf_a_n, byp_data_n[1]);
    forward_case(3'b111, FWD_OTH, FWD_RS, FWD_RT, byp_data_n[1], byp_data_n[2]);
    byp_wr_n = '0;
    record_result("forward priority", e0);
endtask

task automatic memory_ops();
    int          e0;
    reg_addr_t   rs, rt;
    logic [15:0] off;
    e0     = err_count;
    rs     = reg_number();
    rt     = reg_number();
    off    = imm_value();
    rf_a_n = next_random();
    rf_b_n = next_random();
    apply_instr(next_random(), i_format(OPC_LW, rs, rt, off));
    check_op("alu_op", alu_op, OP_LW);
    check_bit("mem_rd", mem_rd, 1'b1);
    check_bit("mem_wr", mem_wr, 1'b0);
    check_mask("r_mask", r_mask, MASK_WORD);
    check_mask("w_mask", w_mask, MASK_NONE);
    check_bit("regc_wr", regc_wr, 1'b1);
    check_addr("regc_addr", regc_addr, rt);
    check_word("rega_data", rega_data, rf_a_n);
    check_word("regb_data", regb_data, sign_ext(off));
    byp_wr_n      = 3'b001;  // store data comes from the exu
    byp_addr_n[0] = rt;
    byp_data_n[0] = next_random();
    apply_instr(next_random(), i_format(OPC_SW, rs, rt, off));
    check_op("alu_op", alu_op, OP_SW);
    check_bit("mem_wr", mem_wr, 1'b1);
    check_bit("mem_rd", mem_rd, 1'b0);
    check_mask("w_mask", w_mask, MASK_WORD);
    check_mask("r_mask", r_mask, MASK_NONE);
    check_bit("regc_wr", regc_wr, 1'b0);
    check_word("store_data", store_data, byp_data_n[0]);
    byp_wr_n = '0;
    record_result("memory ops", e0);
endtask

task automatic branch_case(input logic [5:0] opc, input alu_op_e op);
    reg_addr_t   rs, rt;
    logic [15:0] off;
    word_t       p;
    rs  = reg_number();
    rt  = (op == OP_BEQ || op == OP_BNE) ? reg_number() : 5'd0;
    off = imm_value();
    p   = next_random() & 32'hffff_fffc;
    apply_instr(p, i_format(opc, rs, rt, off));
    check_op("alu_op", alu_op, op);
    check_bit("jce", jce, branch_taken(op, rf_a_n, rf_b_n));
    check_word("jaddr", jaddr, p + 32'd4 + (sign_ext(off) << 2));
    check_bit("regc_wr", regc_wr, 1'b0);
endtask

task automatic branch_resolution();
    int e0;
    e0 = err_count;
    for (int r = 0; r < BR_ROUNDS; r++) begin
        rf_a_n = next_random();
        if (r % 4 == 1) begin
            rf_a_n[31] = 1'b0;  // positive
        end else if (r % 4 == 2) begin
            rf_a_n[31] = 1'b1;  // negative
        end else if (r % 4 == 3) begin
            rf_a_n = '0;
        end
        if (r % 2 == 0) begin
            rf_b_n = rf_a_n;  // beq taken, bne not
        end else begin
            rf_b_n = next_random();
        end
        branch_case(OPC_BEQ, OP_BEQ);
        branch_case(OPC_BNE, OP_BNE);
        branch_case(OPC_BLEZ, OP_BLEZ);
        branch_case(OPC_BGTZ, OP_BGTZ);
        branch_case(OPC_REGIMM, OP_BLTZ);
    end
    record_result("branch resolution", e0);
endtask

task automatic jump_case(input logic [5:0] opc, input alu_op_e op);
    word_t p;
    word_t p4;
    word_t w;
    p  = next_random() & 32'hffff_fffc;
    p4 = p + 32'd4;
    w  = next_random();
    apply_instr(p, {opc, w[31:6]});
    check_op("alu_op", alu_op, op);
    check_bit("jce", jce, 1'b1);
    check_word("jaddr", jaddr, {p4[31:28], w[31:6], 2'b00});
    check_bit("regc_wr", regc_wr, op == OP_JAL);
    if (op == OP_JAL) begin
        check_addr("regc_addr", regc_addr, LINK_REG);
        check_word("rega_data", rega_data, p);
        check_word("regb_data", regb_data, LINK_OFFSET);
    end
endtask

task automatic jump_resolution();
    int        e0;
    reg_addr_t rs;
    e0 = err_count;
    jump_case(OPC_J, OP_J);
    jump_case(OPC_JAL, OP_JAL);
    rs            = reg_number();
    byp_wr_n      = 3'b010;  // jr target forwarded from mem
    byp_addr_n[1] = rs;
    byp_data_n[1] = next_random();
    apply_instr(next_random(), r_format(rs, 5'd0, 5'd0, 5'd0, FN_JR));
    check_op("alu_op", alu_op, OP_JR);
    check_bit("jce", jce, 1'b1);
    check_word("jaddr", jaddr, byp_data_n[1]);
    check_bit("regc_wr", regc_wr, 1'b0);
    byp_wr_n = '0;
    apply_instr(next_random(), i_format(6'h3f, reg_number(), reg_number(), imm_value()));
    verify_inactive(OP_UNKNOWN);
    record_result("jump resolution", e0);
endtask

`endif

//--- tb/tb_decode_top.sv
// directed testbench for decode_top with three bypass sources, random values come from a fixed-seed LCG
`timescale 1ns/1ps

module tb_decode_top
    import decode_pkg::*;
();

    localparam int NUM_BYPASS = 3;
    localparam int CLK_PERIOD = 100;

    logic                       clk;
    logic                       rst;
    word_t                      pc;
    word_t                      inst;
    word_t                      rega_data_in;
    word_t                      regb_data_in;
    logic      [NUM_BYPASS-1:0] byp_wr;
    reg_addr_t [NUM_BYPASS-1:0] byp_addr;
    word_t     [NUM_BYPASS-1:0] byp_data;
    reg_addr_t                  rega_addr;
    reg_addr_t                  regb_addr;
    alu_op_e                    alu_op;
    word_t                      rega_data;
    word_t                      regb_data;
    word_t                      store_data;
    logic                       mem_wr;
    logic                       mem_rd;
    mask_t                      w_mask;
    mask_t                      r_mask;
    logic                       regc_wr;
    reg_addr_t                  regc_addr;
    logic                       jce;
    word_t                      jaddr;

    // values for the next drive edge
    word_t                      rf_a_n;
    word_t                      rf_b_n;
    logic      [NUM_BYPASS-1:0] byp_wr_n;
    reg_addr_t [NUM_BYPASS-1:0] byp_addr_n;
    word_t     [NUM_BYPASS-1:0] byp_data_n;

    int    err_count  = 0;
    int    pass_tests = 0;
    int    fail_tests = 0;
    word_t lcg_state  = 32'h7808;

    `include "decode_tests.svh"

    decode_top #(
        .NUM_BYPASS (NUM_BYPASS)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .inst         (inst),
        .rega_data_in (rega_data_in),
        .regb_data_in (regb_data_in),
        .byp_wr       (byp_wr),
        .byp_addr     (byp_addr),
        .byp_data     (byp_data),
        .rega_addr    (rega_addr),
        .regb_addr    (regb_addr),
        .alu_op       (alu_op),
        .rega_data    (rega_data),
        .regb_data    (regb_data),
        .store_data   (store_data),
        .mem_wr       (mem_wr),
        .mem_rd       (mem_rd),
        .w_mask       (w_mask),
        .r_mask       (r_mask),
        .regc_wr      (regc_wr),
        .regc_addr    (regc_addr),
        .jce          (jce),
        .jaddr        (jaddr)
    );

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input mask_t got, input mask_t exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // one instruction through the stage register, returns at the falling edge after capture
    task automatic apply_instr(input word_t p, input word_t i);
        @(posedge clk);
        pc           <= p;
        inst         <= i;
        rega_data_in <= rf_a_n;
        regb_data_in <= rf_b_n;
        byp_wr       <= byp_wr_n;
        byp_addr     <= byp_addr_n;
        byp_data     <= byp_data_n;
        @(posedge clk);  // captured here
        @(negedge clk);
    endtask

    task automatic record_result(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("%-18s ok", name);
        end else begin
            fail_tests++;
            $display("%-18s FAILED with %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst          = 1'b1;
        pc           = '0;
        inst         = '0;
        rega_data_in = '0;
        regb_data_in = '0;
        byp_wr       = '0;
        byp_addr     = '0;
        byp_data     = '0;
        rf_a_n       = '0;
        rf_b_n       = '0;
        byp_wr_n     = '0;
        byp_addr_n   = '0;
        byp_data_n   = '0;
        reset_state();
        alu_decode();
        forward_priority();
        memory_ops();
        branch_resolution();
        jump_resolution();
        $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // run length from the instruction count of all tests plus a margin
    initial begin
        #((TEST_CYCLES + 50) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- list.f
+incdir+tb
design/decode_pkg.sv
design/id_operand_fetch.sv
design/instr_decoder.sv
design/operand_mux.sv
design/branch_unit.sv
design/decode_top.sv
tb/tb_decode_top.sv
